// File: Bender.yml
package:
  name: irq_unit

sources:
  - logic/irq_pkg.sv
  - logic/irq_flag_regs.sv
  - logic/irq_latch.sv
  - logic/irq_sequencer.sv
  - logic/irq_unit.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_irq_unit.sv

// File: files.f
logic/irq_pkg.sv
logic/irq_flag_regs.sv
logic/irq_latch.sv
logic/irq_sequencer.sv
logic/irq_unit.sv
tests/tb_clock_gen.sv
tests/tb_irq_unit.sv

// File: logic/irq_flag_regs.sv
/* Enable and mask registers, flag write decode into loads and clears,
   combined flag and status read word */
`timescale 1ns/10ps

module irq_flag_regs #(
	parameter bit ext_source = 1'b1
) (
	input  logic              sys_clk,
	input  logic              resetl,
	input  irq_pkg::bus_req_t bus,
	input  irq_pkg::irq_vec_t latched,
	input  logic              imask_set,
	output irq_pkg::irq_cfg_t cfg,
	output irq_pkg::irq_vec_t clr,
	output irq_pkg::bus_rsp_t rsp
);
	import irq_pkg::*;

	irq_vec_t    enable_q;
	logic        imask_q;
	logic        mask_clr;
	irq_vec_t    ena_wdata;
	logic [17:0] flag_view;
	logic [17:0] stat_view;

	// Enables as carried by the write word
	// Source 5 is tied off when it is not built
	assign ena_wdata[num_low_sources-1:0] = bus.wdata[flag_ena_lo +: num_low_sources];
	assign ena_wdata[num_sources-1] = bus.wdata[flag_ena5_bit] & ext_source;

	// Writing 0 to the mask bit drops the mask
	assign mask_clr = bus.flag_wr & ~bus.wdata[flag_imask_bit];

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			enable_q <= '0;
		end else if (bus.flag_wr) begin
			enable_q <= ena_wdata;
		end
	end

	// Mask set by the first stub fetch
	// Set has priority over a software clear in the same cycle
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			imask_q <= 1'b0;
		end else begin
			imask_q <= imask_set | (imask_q & ~mask_clr);
		end
	end

	// Clear strobes, valid only in the flag write cycle
	always_comb begin
		clr = '0;
		if (bus.flag_wr) begin
			clr[num_low_sources-1:0] = bus.wdata[flag_clr_lo +: num_low_sources];
			clr[num_sources-1] = bus.wdata[flag_clr5_bit] & ext_source;
		end
	end

	// Flag view
	// Clear bits always read back as zero
	always_comb begin
		flag_view = '0;
		flag_view[flag_imask_bit] = imask_q;
		flag_view[flag_ena_lo +: num_low_sources] = enable_q[num_low_sources-1:0];
		flag_view[flag_ena5_bit] = enable_q[num_sources-1];
	end

	// Status view of the sticky latches
	always_comb begin
		stat_view = '0;
		stat_view[stat_lat_lo +: num_low_sources] = latched[num_low_sources-1:0];
		stat_view[stat_lat5_bit] = latched[num_sources-1] & ext_source;
	end

	// Both views merge when both strobes are up
	assign rsp.rdata = (bus.flag_rd ? flag_view : '0) | (bus.stat_rd ? stat_view : '0);
	assign rsp.rd_oe = bus.flag_rd | bus.stat_rd;

	assign cfg.enable = enable_q;
	assign cfg.imask = imask_q;

endmodule

// File: logic/irq_latch.sv
/* Sticky request latches with software clears,
   pending flag and highest-source priority encoder */
`timescale 1ns/10ps

module irq_latch (
	input  logic              sys_clk,
	input  logic              resetl,
	input  irq_pkg::irq_vec_t gpu_irq,
	input  irq_pkg::irq_vec_t enable,
	input  irq_pkg::irq_vec_t clr,
	output irq_pkg::irq_vec_t latched,
	output logic              any_pending,
	output irq_pkg::int_num_t int_num
);
	import irq_pkg::*;

	irq_vec_t latch_q;
	irq_vec_t req_set;

	// Only enabled requests can set a latch
	assign req_set = gpu_irq & enable;

	// Clear beats hold, a live request sets the latch again
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			latch_q <= '0;
		end else begin
			latch_q <= req_set | (latch_q & ~clr);
		end
	end

	assign latched = latch_q;
	assign any_pending = |latch_q;

	// Highest set source wins
	// Source 0 alone and no source both give 0
	always_comb begin
		int_num = '0;
		for (int i = 1; i < num_sources; i++) begin
			if (latch_q[i]) begin
				int_num = int_num_t'(i);
			end
		end
	end

endmodule

// File: logic/irq_pkg.sv
/* Shared types for the interrupt unit: source vectors, bus request and response structs,
   register configuration, flag and status word bit positions and the fixed stub words */
package irq_pkg;

	// Request lines, the last one optional
	localparam int num_sources = 6;
	// Sources 0 to 4 sit in one contiguous field of the flag and status words
	localparam int num_low_sources = num_sources - 1;

	// One bit per source
	typedef logic [num_sources-1:0] irq_vec_t;
	// Source number
	typedef logic [2:0] int_num_t;
	// RISC instruction word
	typedef logic [15:0] instr_t;

	// Register access from the CPU data bus
	typedef struct packed {
		logic [31:0] wdata;
		logic        flag_wr;
		logic        flag_rd;
		logic        stat_rd;
	} bus_req_t;

	// Read word and its valid level
	typedef struct packed {
		logic [17:0] rdata;
		logic        rd_oe;
	} bus_rsp_t;

	// Software-visible configuration
	typedef struct packed {
		irq_vec_t enable;
		logic     imask;
	} irq_cfg_t;

	// Flag word layout
	localparam int flag_imask_bit = 3;
	localparam int flag_ena_lo = 4;
	localparam int flag_clr_lo = 9;
	localparam int flag_ena5_bit = 16;
	localparam int flag_clr5_bit = 17;

	// Status word layout
	localparam int stat_lat_lo = 6;
	localparam int stat_lat5_bit = 16;

	// Fixed stub words, entries 0 to 3 are words 0 to 3, entries 4 and 5 are words 6 and 7
	localparam instr_t stub_words [0:5] = '{
		16'h1C9F,
		16'hCC1E,
		16'hBFFE,
		16'h981E,
		16'hD3C0,
		16'hE400
	};

endpackage

// File: logic/irq_sequencer.sv
/* Service flag, stub fetch counter and stub instruction generator
   with the vectored service address */
`timescale 1ns/10ps

module irq_sequencer #(
	parameter logic [31:0] service_base = 32'h00F03000
) (
	input  logic              sys_clk,
	input  logic              resetl,
	input  logic              any_pending,
	input  irq_pkg::int_num_t int_num,
	input  logic              imask,
	input  logic              atomic,
	input  logic              romold,
	output logic              intser,
	output logic              imask_set,
	output irq_pkg::instr_t   intins
);
	import irq_pkg::*;

	localparam logic [2:0] last_word = 3'd7;

	logic       intser_q;
	logic [2:0] fetch_cnt;
	logic       isr_set;
	logic       isr_clr;
	logic       fetch_en;
	instr_t     vec_lo;
	instr_t     vec_hi;

	// Enter service only when unmasked, outside an atomic sequence and not already in service
	assign isr_set = any_pending & ~imask & ~atomic & ~intser_q;

	// Each CPU fetch during service consumes one stub word
	assign fetch_en = romold & intser_q;

	// Eighth fetch ends service
	assign isr_clr = fetch_en & (fetch_cnt == last_word);

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			intser_q <= 1'b0;
		end else begin
			intser_q <= isr_set | (intser_q & ~isr_clr);
		end
	end

	// Counter wraps from 7 to 0 on the last fetch
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			fetch_cnt <= '0;
		end else if (fetch_en) begin
			fetch_cnt <= fetch_cnt + 3'd1;
		end
	end

	// Table entries are 16 bytes apart, eight words per handler
	assign vec_lo = service_base[15:0] + {9'd0, int_num, 4'd0};
	assign vec_hi = service_base[31:16];

	// Stub program
	// 0 moves the stack pointer down by one long word
	// 1 copies the PC into r30, 2 pushes it
	// 3 to 5 load the service address into r30, low half first
	// 6 jumps through r30, 7 fills the delay slot
	always_comb begin
		case (fetch_cnt)
			3'd0: intins = stub_words[0];
			3'd1: intins = stub_words[1];
			3'd2: intins = stub_words[2];
			3'd3: intins = stub_words[3];
			3'd4: intins = vec_lo;
			3'd5: intins = vec_hi;
			3'd6: intins = stub_words[4];
			default: intins = stub_words[5];
		endcase
	end

	assign intser = intser_q;
	// First stub fetch raises the mask in the register block
	assign imask_set = fetch_en;

endmodule

// File: logic/irq_unit.sv
/* Interrupt unit top level joining the flag registers,
   the request latches and the service sequencer */
`timescale 1ns/10ps

module irq_unit #(
	parameter bit          ext_source = 1'b1,
	parameter logic [31:0] service_base = 32'h00F03000
) (
	input  logic              sys_clk,
	input  logic              resetl,
	input  irq_pkg::irq_vec_t gpu_irq,
	input  irq_pkg::bus_req_t bus,
	input  logic              atomic,
	input  logic              romold,
	output irq_pkg::bus_rsp_t rsp,
	output logic              intser,
	output logic              imask,
	output irq_pkg::instr_t   intins
);
	import irq_pkg::*;

	irq_cfg_t cfg;
	irq_vec_t clr;
	irq_vec_t latched;
	logic     any_pending;
	int_num_t int_num;
	logic     imask_set;

	irq_flag_regs #(
		.ext_source(ext_source)
	) i_flag_regs (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.bus      (bus),
		.latched  (latched),
		.imask_set(imask_set),
		.cfg      (cfg),
		.clr      (clr),
		.rsp      (rsp)
	);

	irq_latch i_latch (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.gpu_irq    (gpu_irq),
		.enable     (cfg.enable),
		.clr        (clr),
		.latched    (latched),
		.any_pending(any_pending),
		.int_num    (int_num)
	);

	irq_sequencer #(
		.service_base(service_base)
	) i_sequencer (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.any_pending(any_pending),
		.int_num    (int_num),
		.imask      (cfg.imask),
		.atomic     (atomic),
		.romold     (romold),
		.intser     (intser),
		.imask_set  (imask_set),
		.intins     (intins)
	);

	assign imask = cfg.imask;

endmodule

// File: tests/tb_clock_gen.sv
/* Testbench clock and synchronous reset generator */
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int period_ns = 40,
	parameter int reset_cycles = 16
) (
	output logic sys_clk,
	output logic resetl
);

	initial begin
		sys_clk = 1'b0;
		forever begin
			#(period_ns / 2) sys_clk = ~sys_clk;
		end
	end

	// Reset low for whole cycles, released on a falling edge
	initial begin
		resetl = 1'b0;
		repeat (reset_cycles) @(posedge sys_clk);
		@(negedge sys_clk);
		resetl = 1'b1;
	end

endmodule

// File: tests/tb_irq_unit.sv
/* Directed tests of the interrupt unit with typed compare tasks,
   a watchdog and a closing summary */
`timescale 1ns/10ps

module tb_irq_unit;
	import irq_pkg::*;

	localparam int clk_period_ns = 40;
	localparam int reset_cycles = 16;
	// Eight fetches, each with up to three idle cycles before it
	localparam int stub_cycles = 8 * 4;
	localparam int test_cycles = reset_cycles + 1 + 3 + 2 + 5 + (2 + stub_cycles)
		+ (4 + 1 + 2 + stub_cycles + 1 + 4 + 2);
	// Service table base of the default DUT
	localparam logic [15:0] vec_base_lo = 16'h3000;
	localparam logic [15:0] vec_base_hi = 16'h00F0;

	logic     sys_clk;
	logic     resetl;
	irq_vec_t gpu_irq;
	bus_req_t bus;
	logic     atomic;
	logic     romold;
	bus_rsp_t rsp;
	logic     intser;
	logic     imask;
	instr_t   intins;

	integer   seed;
	int       error_count;
	int       tests_run;
	int       tests_failed;
	int       test_errors_start;
	string    test_name;
	// Expected enables and latches
	irq_vec_t ena_model;
	irq_vec_t lat_model;

	tb_clock_gen #(
		.period_ns   (clk_period_ns),
		.reset_cycles(reset_cycles)
	) i_clock_gen (
		.sys_clk(sys_clk),
		.resetl (resetl)
	);

	irq_unit i_dut (
		.sys_clk(sys_clk),
		.resetl (resetl),
		.gpu_irq(gpu_irq),
		.bus    (bus),
		.atomic (atomic),
		.romold (romold),
		.rsp    (rsp),
		.intser (intser),
		.imask  (imask),
		.intins (intins)
	);

	// Flag write word, mask bit left at 0
	function automatic logic [31:0] flag_wdata(input irq_vec_t ena, input irq_vec_t clr);
		logic [31:0] w;
		w = '0;
		w[8:4] = ena[4:0];
		w[16] = ena[5];
		w[13:9] = clr[4:0];
		w[17] = clr[5];
		return w;
	endfunction

	function automatic logic [17:0] flag_view(input irq_vec_t ena, input logic msk);
		logic [17:0] w;
		w = '0;
		w[3] = msk;
		w[8:4] = ena[4:0];
		w[16] = ena[5];
		return w;
	endfunction

	function automatic logic [17:0] stat_view(input irq_vec_t lat);
		logic [17:0] w;
		w = '0;
		w[10:6] = lat[4:0];
		w[16] = lat[5];
		return w;
	endfunction

	// Number of the highest set source, 0 when none
	function automatic int_num_t highest_source(input irq_vec_t v);
		int_num_t n;
		n = '0;
		for (int i = 0; i < num_sources; i++) begin
			if (v[i]) begin
				n = i[2:0];
			end
		end
		return n;
	endfunction

	// Expected stub word for one fetch count
	function automatic instr_t stub_word(input logic [2:0] k, input int_num_t n);
		case (k)
			3'd0: return 16'h1C9F;
			3'd1: return 16'hCC1E;
			3'd2: return 16'hBFFE;
			3'd3: return 16'h981E;
			3'd4: return vec_base_lo + 16'(n) * 16'd16;
			3'd5: return vec_base_hi;
			3'd6: return 16'hD3C0;
			default: return 16'hE400;
		endcase
	endfunction

	task automatic check_rsp(input string what, input bus_rsp_t exp, input bus_rsp_t act);
		if (act !== exp) begin
			$display("Fail %s %s: expected rdata %h rd_oe %b, actual rdata %h rd_oe %b",
				test_name, what, exp.rdata, exp.rd_oe, act.rdata, act.rd_oe);
			error_count++;
		end
	endtask

	task automatic check_instr(input string what, input instr_t exp, input instr_t act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
			error_count++;
		end
	endtask

	task automatic check_level(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
			error_count++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors_start = error_count;
		tests_run++;
	endtask

	task automatic end_test();
		if (error_count == test_errors_start) begin
			$display("Test %s: passed", test_name);
		end else begin
			$display("Test %s: %0d failed checks", test_name, error_count - test_errors_start);
			tests_failed++;
		end
	endtask

	// One flag write cycle, registers load at the rising edge inside it
	task automatic flag_write(input logic [31:0] wdata);
		bus.wdata = wdata;
		bus.flag_wr = 1'b1;
		@(negedge sys_clk);
		bus.flag_wr = 1'b0;
		bus.wdata = '0;
	endtask

	// Read word checked a quarter period after the strobe goes up
	task automatic read_word(input logic flag, input logic [17:0] exp_data, input string what);
		bus_rsp_t exp;
		exp.rdata = exp_data;
		exp.rd_oe = 1'b1;
		bus.flag_rd = flag;
		bus.stat_rd = ~flag;
		#(clk_period_ns / 4);
		check_rsp(what, exp, rsp);
		@(negedge sys_clk);
		bus.flag_rd = 1'b0;
		bus.stat_rd = 1'b0;
	endtask

	task automatic wait_intser(input int max_cycles);
		int n;
		n = 0;
		while (!intser && n < max_cycles) begin
			@(negedge sys_clk);
			n++;
		end
		if (!intser) begin
			$display("Fail %s: intser did not rise within %0d cycles", test_name, max_cycles);
			error_count++;
		end
	endtask

	task automatic expect_intser_low(input int cycles);
		repeat (cycles) begin
			@(negedge sys_clk);
			check_level("intser while blocked", 1'b0, intser);
		end
	endtask

	// Eight fetch pulses at random gaps, each stub word checked before its fetch
	task automatic run_stub(input int_num_t n);
		int gap;
		for (int k = 0; k < 8; k++) begin
			gap = $random(seed) & 3;
			repeat (gap) @(negedge sys_clk);
			check_level("intser before fetch", 1'b1, intser);
			if (k == 0) begin
				check_level("imask before first fetch", 1'b0, imask);
			end
			check_instr($sformatf("stub word %0d", k), stub_word(k[2:0], n), intins);
			romold = 1'b1;
			@(negedge sys_clk);
			romold = 1'b0;
			if (k == 0) begin
				check_level("imask after first fetch", 1'b1, imask);
			end
		end
		check_level("intser after eighth fetch", 1'b0, intser);
	endtask

	task automatic reset_state();
		start_test("reset_state");
		check_level("intser", 1'b0, intser);
		check_level("imask", 1'b0, imask);
		check_instr("first stub word", 16'h1C9F, intins);
		read_word(1'b1, '0, "flag read");
		read_word(1'b0, '0, "status read");
		// No strobe, no valid read word
		#(clk_period_ns / 4);
		check_rsp("idle bus", '0, rsp);
		@(negedge sys_clk);
		end_test();
	endtask

	task automatic enable_readback();
		integer rnd;
		start_test("enable_readback");
		rnd = $random(seed);
		ena_model = rnd[5:0];
		ena_model[5] = 1'b1;
		// All clear bits set, nothing is latched yet
		flag_write(flag_wdata(ena_model, '1));
		read_word(1'b1, flag_view(ena_model, 1'b0), "flag readback");
		end_test();
	endtask

	task automatic latch_and_clear();
		integer rnd;
		irq_vec_t req;
		irq_vec_t clr;
		start_test("latch_and_clear");
		atomic = 1'b1;
		// Sources 1, 3 and 4 always enabled, source 0 never
		rnd = $random(seed);
		ena_model = (rnd[5:0] | 6'b011010) & ~6'b000001;
		flag_write(flag_wdata(ena_model, '0));
		rnd = $random(seed);
		req = rnd[5:0] | 6'b011011;
		gpu_irq = req;
		@(negedge sys_clk);
		gpu_irq = '0;
		lat_model = req & ena_model;
		read_word(1'b0, stat_view(lat_model), "status after requests");
		check_level("intser under atomic", 1'b0, intser);
		// Sources 1 and 4 survive, source 3 always cleared
		rnd = $random(seed);
		clr = (lat_model & rnd[5:0] & ~6'b010010) | 6'b001000;
		flag_write(flag_wdata(ena_model, clr));
		lat_model = lat_model & ~clr;
		read_word(1'b0, stat_view(lat_model), "status after clear");
		check_level("intser after clear", 1'b0, intser);
		end_test();
	endtask

	task automatic service_stub();
		start_test("service_stub");
		atomic = 1'b0;
		wait_intser(2);
		run_stub(highest_source(lat_model));
		end_test();
	endtask

	task automatic mask_and_atomic();
		start_test("mask_and_atomic");
		check_level("imask left by service", 1'b1, imask);
		expect_intser_low(4);
		// Mask dropped by software, latches still pending
		flag_write(flag_wdata(ena_model, '0));
		check_level("imask after flag write", 1'b0, imask);
		wait_intser(2);
		run_stub(highest_source(lat_model));
		// Atomic sequence holds service off after the mask drops
		atomic = 1'b1;
		flag_write(flag_wdata(ena_model, '0));
		check_level("imask under atomic", 1'b0, imask);
		expect_intser_low(4);
		atomic = 1'b0;
		wait_intser(2);
		end_test();
	endtask

	initial begin
		#(test_cycles * 2 * clk_period_ns);
		$display("Timeout: the tests did not finish within %0d cycles", test_cycles * 2);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		seed = 32'h933c;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		test_errors_start = 0;
		test_name = "";
		ena_model = '0;
		lat_model = '0;
		gpu_irq = '0;
		bus = '0;
		atomic = 1'b0;
		romold = 1'b0;
		@(posedge resetl);
		@(negedge sys_clk);
		reset_state();
		enable_readback();
		latch_and_clear();
		service_stub();
		mask_and_atomic();
		$display("Tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
